// File: cache_base.f
verilog/cache_geom_pkg.sv
verilog/cache_msg_pkg.sv
verilog/cache_ctrl.sv
verilog/cache_dpath.sv
verilog/cache_base.sv
dv/cache_base_sva.sv
dv/cache_base_tb.sv

// File: dv/cache_base_sva.sv
`timescale 1ns/1ps
`default_nettype none

module cache_base_sva (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      memreq_rdy,
  input  cache_msg_pkg::mem_resp_t  memresp,
  input  logic                      memresp_val,
  input  logic                      memresp_rdy,
  input  cache_msg_pkg::mem_req_t   cache_req,
  input  logic                      cache_req_val,
  input  logic                      cache_req_rdy,
  input  logic                      cache_resp_val,
  input  logic                      cache_resp_rdy
);

  logic [3:0] outstanding;                  // Memory requests awaiting a response

  always_ff @(posedge clk) begin
    if (reset) begin
      outstanding <= '0;
    end else begin
      outstanding <= outstanding + 4'(cache_req_val && cache_req_rdy)
                                 - 4'(cache_resp_val && cache_resp_rdy);
    end
  end

  //----------------------------------------------------------------------
  // Handshake stability
  //----------------------------------------------------------------------

  a_memresp_hold: assert property (@(posedge clk) disable iff (reset)
    memresp_val && !memresp_rdy |=> memresp_val && $stable(memresp))
    else $error("memresp changed while stalled");

  a_cache_req_hold: assert property (@(posedge clk) disable iff (reset)
    cache_req_val && !cache_req_rdy |=> cache_req_val && $stable(cache_req))
    else $error("cache_req changed while stalled");

  // Quiet outputs right after reset
  a_reset_quiet: assert property (@(posedge clk)
    reset |=> !memresp_val && !cache_req_val && memreq_rdy)
    else $error("outputs active after reset");

  // Miss handling only while the pipe is closed
  a_resp_rdy_when_busy: assert property (@(posedge clk) disable iff (reset)
    outstanding != 0 |-> cache_resp_rdy && !memreq_rdy)
    else $error("memory response pending outside a miss");

  a_resp_rdy_not_pipe: assert property (@(posedge clk) disable iff (reset)
    !(cache_resp_rdy && memreq_rdy))
    else $error("cache_resp_rdy high while accepting requests");

endmodule

bind cache_base cache_base_sva sva_i (
  .clk(clk), .reset(reset), .memreq_rdy(memreq_rdy),
  .memresp(memresp), .memresp_val(memresp_val), .memresp_rdy(memresp_rdy),
  .cache_req(cache_req), .cache_req_val(cache_req_val), .cache_req_rdy(cache_req_rdy),
  .cache_resp_val(cache_resp_val), .cache_resp_rdy(cache_resp_rdy)
);

`default_nettype wire

// File: dv/cache_base_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cache_base_tb;

  import cache_msg_pkg::*;
  import cache_geom_pkg::*;

  localparam int MEM_WORDS  = 1024;
  localparam int WAIT_LIMIT = 2000;           // Cycles per directed wait

  logic        clk;
  logic        reset;
  mem_req_t    memreq;
  logic        memreq_val;
  logic        memreq_rdy;
  mem_resp_t   memresp;
  logic        memresp_val;
  logic        memresp_rdy;
  mem_req_t    cache_req;
  logic        cache_req_val;
  logic        cache_req_rdy;
  mem_resp_t   cache_resp;
  logic        cache_resp_val;
  logic        cache_resp_rdy;

  logic [DATA_W-1:0] mem [MEM_WORDS];         // Backing memory
  logic [DATA_W-1:0] ref_mem [MEM_WORDS];     // Architectural view
  mem_req_t    req_q [$];                     // Requests still to be offered
  mem_resp_t   exp_q [$];                     // Expected responses in order
  mem_resp_t   mem_resp_q [$];                // Memory answers not yet taken
  logic        throttle;
  logic        hold_resp;
  logic [7:0]  next_opaque;
  int          pending_w;                     // Word of the newest accepted write
  logic [31:0] pending_old;                   // Its value before that write
  int          mismatches;
  int          other_errors;
  int          mem_rd_cnt;
  int          mem_wr_cnt;
  int          mem_req_idx;

  cache_base dut_i (.*);

  initial clk = 1'b0;
  always #20 clk = ~clk;

  function automatic int word_of(input logic [31:0] addr);
    return int'(addr[11:2]);
  endfunction

  task automatic send(input msg_type_e t, input logic [31:0] addr, input logic [31:0] data);
    mem_req_t r;
    r.mtype  = t;
    r.opaque = next_opaque;
    r.addr   = addr;
    r.data   = data;
    next_opaque++;
    req_q.push_back(r);
  endtask

  //----------------------------------------------------------------------
  // Processor side driver and reference model
  //----------------------------------------------------------------------

  task automatic note_accept(input mem_req_t r);
    mem_resp_t e;
    int        w;
    w        = word_of(r.addr);
    e.mtype  = r.mtype;
    e.opaque = r.opaque;
    e.data   = ref_mem[w];
    pending_w = -1;
    if (r.mtype == MSG_WRITE) begin
      pending_w   = w;
      pending_old = ref_mem[w];
      ref_mem[w]  = r.data;
      e.data      = '0;                       // Write acks carry no data
    end
    exp_q.push_back(e);
  endtask

  task automatic check_resp(input mem_resp_t got);
    mem_resp_t e;
    if (exp_q.size() == 0) begin
      $display("Response arrived with no request outstanding");
      other_errors++;
    end else begin
      e = exp_q.pop_front();
      assert (got.opaque == e.opaque) else begin
        $display("MISMATCH memresp.opaque: got %h expected %h", got.opaque, e.opaque);
        mismatches++;
      end
      assert (got.mtype == e.mtype) else begin
        $display("MISMATCH memresp.mtype: got %h expected %h", got.mtype, e.mtype);
        mismatches++;
      end
      assert (got.data == e.data) else begin
        $display("MISMATCH memresp.data: got %h expected %h", got.data, e.data);
        mismatches++;
      end
    end
  endtask

  always @(posedge clk) begin
    if (reset) begin
      memreq_val  <= 1'b0;
      memresp_rdy <= 1'b0;
    end else begin
      if (memreq_val && memreq_rdy) begin
        note_accept(memreq);
        void'(req_q.pop_front());
      end
      if (memresp_val && memresp_rdy) check_resp(memresp);
      if (memreq_val && !memreq_rdy) begin
        memreq_val <= 1'b1;                   // Hold until taken
      end else if (req_q.size() != 0 && (!throttle || $urandom_range(3) != 0)) begin
        memreq_val <= 1'b1;
        memreq     <= req_q[0];
      end else begin
        memreq_val <= 1'b0;
      end
      memresp_rdy <= !hold_resp && (!throttle || $urandom_range(3) != 0);
    end
  end

  //----------------------------------------------------------------------
  // Memory model answering one request per cycle in order
  //----------------------------------------------------------------------

  task automatic serve_mem(input mem_req_t r);
    mem_resp_t   rsp;
    int          w;
    logic [31:0] want;
    w = word_of(r.addr);
    assert (r.addr[31:12] == '0 && r.addr[1:0] == 2'b00) else begin
      $display("Memory request to address %h is outside the test range", r.addr);
      other_errors++;
    end
    assert (r.addr[3:2] == mem_req_idx[1:0]) else begin  // Line walked word by word
      $display("MISMATCH cache_req.addr: got %h expected offset %h", r.addr, mem_req_idx[1:0]);
      mismatches++;
    end
    mem_req_idx++;
    rsp.mtype  = r.mtype;
    rsp.opaque = r.opaque;
    if (r.mtype == MSG_WRITE) begin
      assert (r.data == ref_mem[w]) else begin          // Victim must be current
        $display("MISMATCH cache_req.data: got %h expected %h", r.data, ref_mem[w]);
        mismatches++;
      end
      mem[w]   = r.data;
      rsp.data = '0;
      mem_wr_cnt++;
    end else begin
      want = (w == pending_w) ? pending_old : ref_mem[w];  // Missing write not applied yet
      assert (mem[w] == want) else begin
        $display("MISMATCH mem[%h]: got %h expected %h", w, mem[w], want);
        mismatches++;
      end
      rsp.data = mem[w];
      mem_rd_cnt++;
    end
    mem_resp_q.push_back(rsp);
  endtask

  always @(posedge clk) begin
    if (reset) begin
      cache_req_rdy  <= 1'b0;
      cache_resp_val <= 1'b0;
      mem_resp_q.delete();
    end else begin
      if (cache_resp_val && cache_resp_rdy) void'(mem_resp_q.pop_front());
      if (cache_req_val && cache_req_rdy) serve_mem(cache_req);
      cache_req_rdy <= !throttle || $urandom_range(3) != 0;
      if (mem_resp_q.size() != 0) begin
        cache_resp_val <= 1'b1;
        cache_resp     <= mem_resp_q[0];
      end else begin
        cache_resp_val <= 1'b0;
      end
    end
  end

  //----------------------------------------------------------------------
  // Sequence
  //----------------------------------------------------------------------

  task automatic wait_idle(input string what, input int limit);
    int n;
    n = 0;
    while ((req_q.size() != 0 || exp_q.size() != 0 || memreq_val) && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (n >= limit) begin
      $display("Timeout waiting for %s to drain", what);
      other_errors++;
    end
  endtask

  initial begin
    int          n;
    int          rd0;
    int          wr0;
    mem_resp_t   held;
    cache_addr_u a;
    logic [5:0]  r;
    void'($urandom(32'ha2eb));
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i]     = 32'h5a5a_0000 ^ (32'(i) * 32'h0001_0193) ^ (32'(i) << 20);
      ref_mem[i] = mem[i];
    end
    reset = 1'b1;
    memreq = '0;
    memreq_val = 1'b0;
    memresp_rdy = 1'b0;
    cache_req_rdy = 1'b0;
    cache_resp = '0;
    cache_resp_val = 1'b0;
    throttle = 1'b0;
    hold_resp = 1'b0;
    next_opaque = '0;
    pending_w = -1;
    pending_old = '0;
    {mismatches, other_errors, mem_rd_cnt, mem_wr_cnt, mem_req_idx} = '0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;

    // Cold read miss fetches one line
    @(negedge clk);
    rd0 = mem_rd_cnt;
    send(MSG_READ, 32'h0000_0040, '0);
    wait_idle("cold read", WAIT_LIMIT);
    assert (mem_rd_cnt - rd0 == 4) else begin
      $display("MISMATCH mem_rd_cnt: got %h expected %h", mem_rd_cnt - rd0, 4);
      mismatches++;
    end

    // Write hit then read hit while memory stays stale
    rd0 = mem_rd_cnt;
    send(MSG_WRITE, 32'h0000_0044, 32'hc0ff_ee01);
    send(MSG_READ, 32'h0000_0044, '0);
    wait_idle("write then read", WAIT_LIMIT);
    assert (mem_rd_cnt == rd0) else begin
      $display("MISMATCH mem_rd_cnt: got %h expected %h", mem_rd_cnt, rd0);
      mismatches++;
    end
    assert (mem[word_of(32'h44)] != ref_mem[word_of(32'h44)]) else begin
      $display("Write hit reached memory before the line was evicted");
      other_errors++;
    end

    // Same index and other tag so the dirty victim goes out first
    wr0 = mem_wr_cnt;
    send(MSG_READ, 32'h0000_0148, '0);
    wait_idle("conflict read", WAIT_LIMIT);
    assert (mem_wr_cnt - wr0 == 4) else begin
      $display("MISMATCH mem_wr_cnt: got %h expected %h", mem_wr_cnt - wr0, 4);
      mismatches++;
    end

    // Processor back-pressure
    hold_resp = 1'b1;
    send(MSG_READ, 32'h0000_0140, '0);
    send(MSG_READ, 32'h0000_0144, '0);
    send(MSG_READ, 32'h0000_0148, '0);
    n = 0;
    while (!memresp_val && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!memresp_val) begin
      $display("Timeout waiting for a response under back-pressure");
      other_errors++;
    end
    held = memresp;
    repeat (5) begin
      @(negedge clk);
      assert (!memreq_rdy && memresp == held) else begin
        $display("MISMATCH memresp: got %h expected %h, memreq_rdy %h", memresp, held,
                 memreq_rdy);
        mismatches++;
      end
    end
    hold_resp = 1'b0;
    wait_idle("held responses", WAIT_LIMIT);

    // Random traffic over four tags and four lines
    @(negedge clk);
    throttle = 1'b1;
    for (int i = 0; i < 300; i++) begin
      r = 6'($urandom_range(63));
      a.flat = '0;
      a.f.tag = TAG_W'(r[5:4]);
      a.f.index = INDEX_W'(r[3:2]);
      a.f.offset = r[1:0];
      send(($urandom_range(1) != 0) ? MSG_WRITE : MSG_READ, a.flat, $urandom);
    end
    wait_idle("random traffic", 40000);
    throttle = 1'b0;

    repeat (4) @(negedge clk);
    $display("Errors: %0d mismatches, %0d other failures", mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the cache testbench with Verilator, then judge the log.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f cache_base.f --top-module cache_base_tb \
  -Mdir obj_dir -o cache_base_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/cache_base_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" "$LOG"; then
  exit 1
fi
if ! grep -q "Test completed successfully" "$LOG"; then
  exit 1
fi
exit 0

// File: verilog/cache_base.sv
`timescale 1ns/1ps
`default_nettype none

module cache_base (
  input  logic                      clk,
  input  logic                      reset,

  // Processor side
  input  cache_msg_pkg::mem_req_t   memreq,
  input  logic                      memreq_val,
  output logic                      memreq_rdy,
  output cache_msg_pkg::mem_resp_t  memresp,
  output logic                      memresp_val,
  input  logic                      memresp_rdy,

  // Memory side
  output cache_msg_pkg::mem_req_t   cache_req,
  output logic                      cache_req_val,
  input  logic                      cache_req_rdy,
  input  cache_msg_pkg::mem_resp_t  cache_resp,
  input  logic                      cache_resp_val,
  output logic                      cache_resp_rdy
);

  import cache_msg_pkg::*;

  //--------------------------------------------------------------------
  // Control to datapath
  //--------------------------------------------------------------------

  logic       reg_en_m0;
  logic       reg_en_m1;
  logic       tarray_wen;
  logic       darray_wen;
  logic       dirty_set;
  logic       dirty_clear;
  logic       mem_addr_sel;
  logic       word_cnt_clear;
  logic       spill_word_sent;
  logic       refill_word_sent;
  logic       refill_word_recv;
  msg_type_e  cache_req_type;

  // Status back to control
  logic       tarray_match;
  logic       victim_dirty;
  msg_type_e  m0_type;
  logic       m1_valid;
  logic       req_count_done;
  logic       resp_count_done;

  cache_ctrl ctrl_i (.*);

  cache_dpath dpath_i (.*);

endmodule

`default_nettype wire

// File: verilog/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
  input  logic                      clk,
  input  logic                      reset,

  // Processor side handshakes
  input  logic                      memreq_val,
  output logic                      memreq_rdy,
  output logic                      memresp_val,
  input  logic                      memresp_rdy,

  // Memory side handshakes
  output logic                      cache_req_val,
  input  logic                      cache_req_rdy,
  output cache_msg_pkg::msg_type_e  cache_req_type,
  input  logic                      cache_resp_val,
  output logic                      cache_resp_rdy,

  // Control to datapath
  output logic                      reg_en_m0,
  output logic                      reg_en_m1,
  output logic                      tarray_wen,
  output logic                      darray_wen,
  output logic                      dirty_set,
  output logic                      dirty_clear,
  output logic                      mem_addr_sel,       // 1 picks the victim tag
  output logic                      word_cnt_clear,
  output logic                      spill_word_sent,
  output logic                      refill_word_sent,
  output logic                      refill_word_recv,   // Any memory response word

  // Status from datapath
  input  logic                      tarray_match,
  input  logic                      victim_dirty,
  input  cache_msg_pkg::msg_type_e  m0_type,
  input  logic                      m1_valid,
  input  logic                      req_count_done,
  input  logic                      resp_count_done
);

  import cache_msg_pkg::*;

  typedef enum logic [1:0] {
    PIPE,
    SPILL,
    REFILL
  } state_e;

  state_e state;
  state_e state_next;
  logic   m0_val;                           // M0 holds a request
  logic   m1_stall;
  logic   m0_hit;
  logic   m0_go;
  logic   m0_miss;
  logic   req_go;
  logic   write_go;

  //--------------------------------------------------------------------
  // M1 stage
  //--------------------------------------------------------------------

  assign memresp_val = m1_valid;
  assign m1_stall    = m1_valid && !memresp_rdy;   // Processor back-pressure
  assign reg_en_m1   = !m1_stall;

  //--------------------------------------------------------------------
  // M0 stage
  //--------------------------------------------------------------------

  assign m0_hit  = m0_val && tarray_match && (state == PIPE);
  assign m0_miss = m0_val && !tarray_match && (state == PIPE);
  assign m0_go   = m0_hit && !m1_stall;            // Hit moves on to M1

  // Y stage accepts only when M0 frees up this cycle
  assign memreq_rdy = !m1_stall && (!m0_val || m0_hit);
  assign reg_en_m0  = memreq_val && memreq_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      m0_val <= 1'b0;
    end else if (reg_en_m0) begin
      m0_val <= 1'b1;
    end else if (m0_go) begin
      m0_val <= 1'b0;                              // Drained, nothing new
    end
  end

  // Write hit updates the word and marks the line
  assign write_go   = m0_go && (m0_type == MSG_WRITE);
  assign dirty_set  = write_go;

  //--------------------------------------------------------------------
  // Miss FSM
  //--------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= PIPE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      PIPE:    if (m0_miss) state_next = victim_dirty ? SPILL : REFILL;
      SPILL:   if (resp_count_done) state_next = REFILL;   // All acks back
      REFILL:  if (resp_count_done) state_next = PIPE;     // Tag written this cycle
      default: state_next = PIPE;
    endcase
  end

  always_comb begin
    cache_req_val  = 1'b0;
    cache_req_type = MSG_READ;
    cache_resp_rdy = 1'b0;
    mem_addr_sel   = 1'b0;
    tarray_wen     = 1'b0;
    dirty_clear    = 1'b0;
    word_cnt_clear = 1'b0;
    case (state)
      PIPE: begin
        word_cnt_clear = m0_miss;                  // Fresh counts for the miss
      end
      SPILL: begin
        cache_req_val  = !req_count_done;          // Four victim words out
        cache_req_type = MSG_WRITE;
        cache_resp_rdy = 1'b1;
        mem_addr_sel   = 1'b1;
        word_cnt_clear = resp_count_done;          // Counts restart for refill
      end
      REFILL: begin
        cache_req_val  = !req_count_done;
        cache_resp_rdy = 1'b1;
        tarray_wen     = resp_count_done;          // Line complete, claim it
        dirty_clear    = resp_count_done;
      end
      default: begin
        cache_req_val  = 1'b0;
      end
    endcase
  end

  // One-word pulses for the datapath counters
  assign req_go           = cache_req_val && cache_req_rdy;
  assign spill_word_sent  = req_go && (state == SPILL);
  assign refill_word_sent = req_go && (state == REFILL);
  assign refill_word_recv = cache_resp_val && cache_resp_rdy;

  // Refill data goes in as it arrives
  assign darray_wen = write_go || (refill_word_recv && (state == REFILL));

endmodule

`default_nettype wire

// File: verilog/cache_dpath.sv
`timescale 1ns/1ps
`default_nettype none

module cache_dpath (
  input  logic                      clk,
  input  logic                      reset,
  input  cache_msg_pkg::mem_req_t   memreq,
  output cache_msg_pkg::mem_resp_t  memresp,

  input  logic                      reg_en_m0,
  input  logic                      reg_en_m1,
  input  logic                      tarray_wen,
  input  logic                      darray_wen,
  input  logic                      dirty_set,
  input  logic                      dirty_clear,
  input  logic                      mem_addr_sel,
  input  logic                      word_cnt_clear,
  input  logic                      spill_word_sent,
  input  logic                      refill_word_sent,
  input  logic                      refill_word_recv,
  input  cache_msg_pkg::msg_type_e  cache_req_type,

  output cache_msg_pkg::mem_req_t   cache_req,
  input  cache_msg_pkg::mem_resp_t  cache_resp,

  output logic                      tarray_match,
  output logic                      victim_dirty,
  output cache_msg_pkg::msg_type_e  m0_type,
  output logic                      m1_valid,
  output logic                      req_count_done,
  output logic                      resp_count_done
);

  import cache_msg_pkg::*;
  import cache_geom_pkg::*;

  mem_req_t                     m0_req;
  logic                         m0_valid;
  cache_addr_u                  m0_addr;
  cache_addr_u                  mem_addr;
  mem_resp_t                    m1_resp;
  logic [TAG_W-1:0]             tag_array [NUM_LINES];
  logic [DATA_W-1:0]            data_array [NUM_LINES*WORDS_PER_LINE];
  logic [NUM_LINES-1:0]         valid_bits;
  logic [NUM_LINES-1:0]         dirty_bits;
  logic [OFFSET_W-1:0]          req_cnt;
  logic [OFFSET_W-1:0]          resp_cnt;
  logic [INDEX_W-1:0]           idx;
  logic [INDEX_W+OFFSET_W-1:0]  wr_word;
  logic [DATA_W-1:0]            wr_data;
  logic [DATA_W-1:0]            hit_rdata;

  //--------------------------------------------------------------------
  // M0 register and tag check
  //--------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reg_en_m0) m0_req <= memreq;
  end

  // Mirrors the controller's occupancy of M0
  always_ff @(posedge clk) begin
    if (reset) begin
      m0_valid <= 1'b0;
    end else if (reg_en_m0) begin
      m0_valid <= 1'b1;
    end else if (reg_en_m1 && tarray_match) begin
      m0_valid <= 1'b0;
    end
  end

  assign m0_addr      = cache_addr_u'(m0_req.addr);   // Field view
  assign idx          = m0_addr.f.index;
  assign m0_type      = m0_req.mtype;
  assign tarray_match = valid_bits[idx] && (tag_array[idx] == m0_addr.f.tag);
  assign victim_dirty = valid_bits[idx] && dirty_bits[idx];
  assign hit_rdata    = data_array[{idx, m0_addr.f.offset}];

  //--------------------------------------------------------------------
  // Arrays
  //--------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (tarray_wen) tag_array[idx] <= m0_addr.f.tag;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else begin
      if (tarray_wen) valid_bits[idx] <= 1'b1;
      if (dirty_set) begin
        dirty_bits[idx] <= 1'b1;
      end else if (dirty_clear) begin
        dirty_bits[idx] <= 1'b0;                     // Fresh line from memory
      end
    end
  end

  // Refill word lands at the response count, write hit at its own offset
  assign wr_word = refill_word_recv ? {idx, resp_cnt} : {idx, m0_addr.f.offset};
  assign wr_data = refill_word_recv ? cache_resp.data : m0_req.data;

  always_ff @(posedge clk) begin
    if (darray_wen) data_array[wr_word] <= wr_data;
  end

  //--------------------------------------------------------------------
  // M1 register
  //--------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      m1_valid <= 1'b0;
    end else if (reg_en_m1) begin
      m1_valid <= m0_valid && tarray_match;          // Bubble while M0 misses
    end
  end

  always_ff @(posedge clk) begin
    if (reg_en_m1) begin
      m1_resp.mtype  <= m0_req.mtype;
      m1_resp.opaque <= m0_req.opaque;
      m1_resp.data   <= (m0_req.mtype == MSG_WRITE) ? '0 : hit_rdata;
    end
  end

  assign memresp = m1_resp;

  //--------------------------------------------------------------------
  // Word counters, one per direction
  //--------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset || word_cnt_clear) begin
      req_cnt        <= '0;
      req_count_done <= 1'b0;
    end else if (spill_word_sent || refill_word_sent) begin
      req_cnt <= req_cnt + 1'b1;
      if (req_cnt == OFFSET_W'(WORDS_PER_LINE - 1)) req_count_done <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || word_cnt_clear) begin
      resp_cnt        <= '0;
      resp_count_done <= 1'b0;
    end else if (refill_word_recv) begin
      resp_cnt <= resp_cnt + 1'b1;
      if (resp_cnt == OFFSET_W'(WORDS_PER_LINE - 1)) resp_count_done <= 1'b1;
    end
  end

  //--------------------------------------------------------------------
  // Memory request
  //--------------------------------------------------------------------

  always_comb begin
    mem_addr            = '0;
    mem_addr.f.tag      = mem_addr_sel ? tag_array[idx] : m0_addr.f.tag;  // Victim or new
    mem_addr.f.index    = idx;
    mem_addr.f.offset   = req_cnt;
  end

  assign cache_req.mtype  = cache_req_type;
  assign cache_req.opaque = m0_req.opaque;
  assign cache_req.addr   = mem_addr.flat;          // Flat view
  assign cache_req.data   = (cache_req_type == MSG_WRITE) ? data_array[{idx, req_cnt}] : '0;

endmodule

`default_nettype wire

// File: verilog/cache_geom_pkg.sv
`default_nettype none

package cache_geom_pkg;

  //----------------------------------------------------------------------
  // Geometry
  //----------------------------------------------------------------------

  localparam int ADDR_W         = 32;
  localparam int DATA_W         = 32;
  localparam int BYTE_OFF_W     = 2;     // Byte within a word
  localparam int OFFSET_W       = 2;     // Word within a line
  localparam int INDEX_W        = 4;
  localparam int TAG_W          = ADDR_W - INDEX_W - OFFSET_W - BYTE_OFF_W;  // 24
  localparam int NUM_LINES      = 16;
  localparam int WORDS_PER_LINE = 4;

  // Address split, MSB first
  typedef struct packed {
    logic [TAG_W-1:0]      tag;
    logic [INDEX_W-1:0]    index;
    logic [OFFSET_W-1:0]   offset;
    logic [BYTE_OFF_W-1:0] byte_off;
  } cache_addr_fields_t;

  // Same 32 bits, seen flat or split
  typedef union packed {
    logic [ADDR_W-1:0]  flat;
    cache_addr_fields_t f;
  } cache_addr_u;

endpackage

`default_nettype wire

// File: verilog/cache_msg_pkg.sv
`default_nettype none

package cache_msg_pkg;

  //----------------------------------------------------------------------
  // Widths
  //----------------------------------------------------------------------

  localparam int OPAQUE_W = 8;           // Requester tag echoed back

  //----------------------------------------------------------------------
  // Message types
  //----------------------------------------------------------------------

  typedef enum logic {
    MSG_READ  = 1'b0,
    MSG_WRITE = 1'b1
  } msg_type_e;

  // Request of 73 bits
  typedef struct packed {
    msg_type_e                           mtype;   // Read or write
    logic [OPAQUE_W-1:0]                 opaque;  // Returned in the response
    logic [cache_geom_pkg::ADDR_W-1:0]   addr;    // Byte address
    logic [cache_geom_pkg::DATA_W-1:0]   data;    // Write data ignored on reads
  } mem_req_t;

  // Response of 41 bits
  typedef struct packed {
    msg_type_e                           mtype;
    logic [OPAQUE_W-1:0]                 opaque;
    logic [cache_geom_pkg::DATA_W-1:0]   data;    // Zero for write acks
  } mem_resp_t;

endpackage

`default_nettype wire
